/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pe_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/pe_pkg.sv
rtl/src_buf.sv
rtl/p_ctrl.sv
rtl/pe_alu.sv
rtl/res_buf.sv
rtl/pe_top.sv
dv/tb_clk_gen.sv
dv/pe_tb.sv

/* dv/pe_tb.sv */
module pe_tb import pe_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // loads plus len+3 for every command, then room for reads and idle windows
    localparam int load_cycles   = 8 + 16 + 20 + 2;
    localparam int cmd_cycles    = 19 + 10 + 10 + 14 + 3 * 27 + 9 + 8 + 10 + 11 + 11;
    localparam int timeout_limit = load_cycles + cmd_cycles + 600;

    logic              clk;
    logic              rst_n;
    logic              src_v;
    logic [pair_aw:0]  src_a;
    logic [word_w-1:0] src_d;
    logic              start;
    pe_cmd_t           cmd;
    logic [tag_w-1:0]  rd_tag;
    logic              busy;
    logic [data_w-1:0] rd_data;
    logic              done;
    logic [tag_w-1:0]  done_tag;

    logic [data_w-1:0] model_mem [2][1 << elem_aw];  // mirrors host loads
    logic [data_w-1:0] exp_res [res_depth];
    logic              known [res_depth];
    logic [15:0]       lfsr_q;
    int                cycle;
    int                errors;
    int                tests_run;
    int                tests_failed;
    logic [tag_w-1:0]  done_tags [$];
    int                done_cycles [$];

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    pe_top pe_top_i (
        .clk(clk), .rst_n(rst_n),
        .src_v(src_v), .src_a(src_a), .src_d(src_d),
        .start(start), .cmd(cmd), .rd_tag(rd_tag),
        .busy(busy), .rd_data(rd_data), .done(done), .done_tag(done_tag)
    );

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("timeout: run still going after %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // every done pulse with the edge it rose on
    always @(negedge clk) begin
        if (rst_n && done) begin
            done_tags.push_back(done_tag);
            done_cycles.push_back(cycle);
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic pe_cmd_t make_cmd(pe_op_e op, logic bank, int base, int len, int tag);
        pe_cmd_t c;
        c.op   = op;
        c.bank = bank;
        c.base = base[elem_aw-1:0];
        c.len  = len[elem_aw-1:0];
        c.tag  = tag[tag_w-1:0];
        return c;
    endfunction

    // reference reduction straight from the opcode rules
    function automatic logic [data_w-1:0] model_reduce(input pe_cmd_t c);
        logic [data_w-1:0] acc;
        logic [data_w-1:0] e;
        logic [elem_aw-1:0] idx;
        acc = model_mem[c.bank][c.base];
        for (int i = 1; i < c.len; i++) begin
            idx = c.base + elem_aw'(i);  // wraps inside the bank
            e = model_mem[c.bank][idx];
            case (c.op)
                op_add: acc = acc + e;
                op_xor: acc = acc ^ e;
                op_max: if (e > acc) acc = e;
                op_min: if (e < acc) acc = e;
            endcase
        end
        return acc;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic load_pair(input logic bank, input int pair, input logic [word_w-1:0] data);
        src_v = 1'b1;
        src_a = {bank, pair[pair_aw-1:0]};
        src_d = data;
        model_mem[bank][2 * pair]     = data[31:0];
        model_mem[bank][2 * pair + 1] = data[63:32];
        @(negedge clk);
        src_v = 1'b0;
    endtask

    task automatic pulse_start(input pe_cmd_t c);
        start = 1'b1;
        cmd   = c;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic issue(input pe_cmd_t c, output int start_cyc);
        start_cyc = cycle + 1;  // the next rising edge samples start
        exp_res[c.tag] = model_reduce(c);
        known[c.tag] = 1'b1;
        pulse_start(c);
        assert (busy === 1'b1) else report_value("busy", 1, busy);  // rises at the start edge
    endtask

    // busy drops right after the last read is issued
    task automatic wait_idle(input int start_cyc, input int len);
        int waited;
        waited = 0;
        while (busy && waited < len + 16) begin
            @(negedge clk);
            waited++;
        end
        assert (!busy) else begin
            $display("busy still high %0d cycles after start", len + 16);
            errors++;
        end
        assert (cycle - start_cyc == len)
            else report_value("busy length", len, cycle - start_cyc);
    endtask

    task automatic wait_done(input int tag, input int start_cyc, input int len);
        int waited;
        int got_cyc;
        logic [tag_w-1:0] got_tag;
        waited = 0;
        while (done_tags.size() == 0 && waited < len + 16) begin
            @(negedge clk);
            waited++;
        end
        assert (done_tags.size() != 0) else begin
            $display("no done pulse for tag %0d within %0d cycles", tag, len + 16);
            errors++;
        end
        if (done_tags.size() != 0) begin
            got_tag = done_tags.pop_front();
            got_cyc = done_cycles.pop_front();
            assert (got_tag == tag[tag_w-1:0]) else report_value("done_tag", tag, got_tag);
            assert (got_cyc - start_cyc == len + 3)
                else report_value("done latency", len + 3, got_cyc - start_cyc);
        end
    endtask

    task automatic check_entry(input int tag);
        rd_tag = tag[tag_w-1:0];
        @(negedge clk);  // registered read port
        assert (rd_data == exp_res[tag])
            else report_value($sformatf("rd_data (tag %0d)", tag), exp_res[tag], rd_data);
    endtask

    task automatic check_all();
        for (int t = 0; t < res_depth; t++) begin
            if (known[t]) check_entry(t);
        end
    endtask

    task automatic run_cmd(input pe_cmd_t c);
        int sc;
        issue(c, sc);
        wait_idle(sc, c.len);
        wait_done(c.tag, sc, c.len);
        check_entry(c.tag);
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - mark);
        end
    endtask

    task automatic test_add();
        int mark;
        mark = errors;
        for (int p = 0; p < 8; p++) load_pair(1'b0, p, random_bits(64));
        run_cmd(make_cmd(op_add, 1'b0, 0, 16, 1));
        end_test("add over 16 elements", mark);
    endtask

    task automatic test_banks();
        int mark;
        mark = errors;
        for (int p = 0; p < 8; p++) begin
            load_pair(1'b0, p, random_bits(64));
            load_pair(1'b1, p, random_bits(64));
        end
        run_cmd(make_cmd(op_add, 1'b0, 3, 7, 2));  // same range, both banks
        run_cmd(make_cmd(op_add, 1'b1, 3, 7, 3));
        run_cmd(make_cmd(op_xor, 1'b1, 1, 11, 4));
        end_test("bank independence and even/odd split", mark);
    endtask

    task automatic test_opcodes();
        int mark;
        int base;
        int len;
        mark = errors;
        for (int p = 0; p < 20; p++) load_pair(1'b1, p, random_bits(64));
        base = int'(random_bits(4));
        len  = 9 + int'(random_bits(4));
        run_cmd(make_cmd(op_xor, 1'b1, base, len, 5));
        run_cmd(make_cmd(op_max, 1'b1, base, len, 6));
        run_cmd(make_cmd(op_min, 1'b1, base, len, 7));
        check_all();
        end_test("xor, max and min", mark);
    endtask

    task automatic test_overlap();
        int mark;
        int sa;
        int sb;
        int sc;
        mark = errors;
        issue(make_cmd(op_add, 1'b0, 0, 6, 8), sa);
        wait_idle(sa, 6);
        issue(make_cmd(op_max, 1'b0, 4, 5, 9), sb);  // first idle cycle
        wait_idle(sb, 5);
        issue(make_cmd(op_min, 1'b0, 9, 7, 10), sc);
        wait_idle(sc, 7);
        wait_done(8, sa, 6);
        wait_done(9, sb, 5);
        wait_done(10, sc, 7);
        check_all();
        end_test("overlapping commands", mark);
    endtask

    task automatic test_dropped();
        int mark;
        int sa;
        mark = errors;
        issue(make_cmd(op_add, 1'b1, 0, 8, 11), sa);
        @(negedge clk);
        pulse_start(make_cmd(op_xor, 1'b1, 2, 4, 3));  // busy, so ignored
        wait_done(11, sa, 8);
        pulse_start(make_cmd(op_add, 1'b0, 0, 0, 1));  // zero length
        repeat (24) @(negedge clk);
        assert (done_tags.size() == 0) else begin
            $display("dropped start still produced %0d done pulses", done_tags.size());
            errors++;
        end
        done_tags.delete();
        done_cycles.delete();
        check_all();
        end_test("dropped starts", mark);
    endtask

    task automatic test_wrap();
        int mark;
        mark = errors;
        load_pair(1'b1, 510, random_bits(64));
        load_pair(1'b1, 511, random_bits(64));
        run_cmd(make_cmd(op_add, 1'b1, 1020, 8, 12));  // 1020..1023 then 0..3
        check_all();
        end_test("wrap-around inside a bank", mark);
    endtask

    initial begin
        src_v        = 1'b0;
        src_a        = '0;
        src_d        = '0;
        start        = 1'b0;
        cmd          = '0;
        rd_tag       = '0;
        cycle        = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_q       = 16'd42922;
        for (int t = 0; t < res_depth; t++) known[t] = 1'b0;
        @(posedge rst_n);  // released on a falling edge
        test_add();
        test_banks();
        test_opcodes();
        test_overlap();
        test_dropped();
        test_wrap();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 20;  // 40 ns clock
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* rtl/p_ctrl.sv */
`default_nettype none

module p_ctrl import pe_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             start,
    input  wire pe_cmd_t          cmd,

    output logic                  busy,
    output logic                  exec,
    output logic      [elem_aw:0] exec_src_addr,
    output pe_ctl_t               elem_ctl
);

    typedef enum logic {
        st_idle,
        st_run
    } state_e;

    state_e             state;
    pe_cmd_t            cmd_q;    // latched command
    logic [elem_aw-1:0] idx;      // current element index
    logic [elem_aw-1:0] cnt;      // elements still to read
    logic               accept;

    // start while busy or with zero length is dropped
    assign accept = start && (state == st_idle) && (cmd.len != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_run;
                        cnt   <= cmd.len;
                    end
                end
                st_run: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == elem_aw'(1)) begin
                        state <= st_idle;   // last read issued this cycle
                    end
                end
            endcase
        end
    end

    // command fields and address stepping
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
            idx   <= cmd.base;
        end else if (exec) begin
            idx <= idx + 1'b1;  // wraps inside the bank
        end
    end

    assign busy = (state == st_run);

    // one read per cycle for the whole run
    assign exec          = (state == st_run);
    assign exec_src_addr = {cmd_q.bank, idx};

    // control pipe, one stage to match the buffer read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            elem_ctl <= '0;
        end else begin
            elem_ctl.valid <= exec;
            elem_ctl.first <= (cnt == cmd_q.len);
            elem_ctl.last  <= (cnt == elem_aw'(1));
            elem_ctl.op    <= cmd_q.op;
            elem_ctl.tag   <= cmd_q.tag;
        end
    end

endmodule

`default_nettype wire

/* rtl/pe_alu.sv */
`default_nettype none

module pe_alu import pe_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire pe_ctl_t           elem_ctl,
    input  wire logic [data_w-1:0] elem,

    output pe_res_t                res
);

    pe_ctl_t           ctl_q;    // input stage
    logic [data_w-1:0] elem_q;
    logic [data_w-1:0] acc;
    logic [data_w-1:0] fold;
    logic [data_w-1:0] acc_nxt;

    // register the incoming element and its control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_q <= '0;
        end else begin
            ctl_q <= elem_ctl;
        end
    end

    always_ff @(posedge clk) begin
        elem_q <= elem;
    end

    // combine by opcode, all unsigned
    always_comb begin
        unique case (ctl_q.op)
            op_add: fold = acc + elem_q;
            op_xor: fold = acc ^ elem_q;
            op_max: fold = (elem_q > acc) ? elem_q : acc;
            op_min: fold = (elem_q < acc) ? elem_q : acc;
        endcase
    end

    // first element starts a new reduction
    assign acc_nxt = ctl_q.first ? elem_q : fold;

    always_ff @(posedge clk) begin
        if (ctl_q.valid) begin
            acc <= acc_nxt;
        end
    end

    // result goes out together with the final accumulate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= ctl_q.valid && ctl_q.last;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_q.valid && ctl_q.last) begin
            res.tag   <= ctl_q.tag;
            res.value <= acc_nxt;
        end
    end

endmodule

`default_nettype wire

/* rtl/pe_pkg.sv */
package pe_pkg;

    // element and host word sizes
    localparam int data_w = 32;
    localparam int word_w = 64;

    // addressing inside one bank
    localparam int elem_aw    = 10;           // element index
    localparam int pair_aw    = 9;            // even/odd pair index
    localparam int pair_depth = 1 << pair_aw;

    // result storage
    localparam int tag_w     = 4;
    localparam int res_depth = 16;

    typedef enum logic [1:0] {
        op_add = 2'd0,  // wrapping sum
        op_xor = 2'd1,
        op_max = 2'd2,  // unsigned
        op_min = 2'd3   // unsigned
    } pe_op_e;

    // host command, len of zero is ignored
    typedef struct packed {
        pe_op_e             op;
        logic               bank;
        logic [elem_aw-1:0] base;
        logic [elem_aw-1:0] len;
        logic [tag_w-1:0]   tag;
    } pe_cmd_t;

    // per-element control, travels next to the read data
    typedef struct packed {
        logic             valid;
        logic             first;  // restarts the accumulator
        logic             last;   // closes the reduction
        pe_op_e           op;
        logic [tag_w-1:0] tag;
    } pe_ctl_t;

    // finished reduction
    typedef struct packed {
        logic              valid;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } pe_res_t;

endpackage

/* rtl/pe_top.sv */
`default_nettype none

module pe_top import pe_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              src_v,
    input  wire logic [pair_aw:0]  src_a,
    input  wire logic [word_w-1:0] src_d,
    input  wire logic              start,
    input  wire pe_cmd_t           cmd,
    input  wire logic [tag_w-1:0]  rd_tag,

    output logic                   busy,
    output logic      [data_w-1:0] rd_data,
    output logic                   done,
    output logic      [tag_w-1:0]  done_tag
);

    logic              exec;
    logic [elem_aw:0]  exec_src_addr;   // bank, element index
    logic [data_w-1:0] exec_src_data;
    pe_ctl_t           elem_ctl;
    pe_res_t           res;

    p_ctrl p_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cmd           (cmd),
        .busy          (busy),
        .exec          (exec),
        .exec_src_addr (exec_src_addr),
        .elem_ctl      (elem_ctl)
    );

    src_buf src_buf_i (
        .clk           (clk),
        .src_v         (src_v),
        .src_a         (src_a),
        .src_d         (src_d),
        .exec          (exec),
        .exec_src_addr (exec_src_addr),
        .exec_src_data (exec_src_data)
    );

    pe_alu pe_alu_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .elem_ctl (elem_ctl),
        .elem     (exec_src_data),
        .res      (res)
    );

    res_buf res_buf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .res      (res),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data),
        .done     (done),
        .done_tag (done_tag)
    );

endmodule

`default_nettype wire

/* rtl/res_buf.sv */
`default_nettype none

module res_buf import pe_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire pe_res_t           res,
    input  wire logic [tag_w-1:0]  rd_tag,

    output logic      [data_w-1:0] rd_data,
    output logic                   done,
    output logic      [tag_w-1:0]  done_tag
);

    logic [data_w-1:0] mem [res_depth];

    // every valid result lands, no back-pressure
    always_ff @(posedge clk) begin
        if (res.valid) begin
            mem[res.tag] <= res.value;
        end
    end

    // host read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_tag];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= res.valid;  // single pulse per result
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            done_tag <= res.tag;
        end
    end

endmodule

`default_nettype wire

/* rtl/src_buf.sv */
`default_nettype none

module src_buf import pe_pkg::*; (
    input  wire logic                clk,
    input  wire logic                src_v,
    input  wire logic [pair_aw:0]    src_a,
    input  wire logic [word_w-1:0]   src_d,
    input  wire logic                exec,
    input  wire logic [elem_aw:0]    exec_src_addr,

    output logic      [data_w-1:0]   exec_src_data
);

    // two banks, each split into even and odd halves
    logic [data_w-1:0] buf0_even [pair_depth];
    logic [data_w-1:0] buf0_odd  [pair_depth];
    logic [data_w-1:0] buf1_even [pair_depth];
    logic [data_w-1:0] buf1_odd  [pair_depth];

    logic               wr_bank;
    logic [pair_aw-1:0] wr_pair;
    logic               rd_bank;
    logic               rd_odd;
    logic [pair_aw-1:0] rd_pair;

    assign wr_bank = src_a[pair_aw];
    assign wr_pair = src_a[pair_aw-1:0];

    // element index bit 0 picks the half
    assign rd_bank = exec_src_addr[elem_aw];
    assign rd_odd  = exec_src_addr[0];
    assign rd_pair = exec_src_addr[elem_aw-1:1];

    // host load writes both halves of one pair
    always_ff @(posedge clk) begin
        if (src_v && !wr_bank) begin
            buf0_even[wr_pair] <= src_d[data_w-1:0];
            buf0_odd[wr_pair]  <= src_d[word_w-1:data_w];
        end
    end

    always_ff @(posedge clk) begin
        if (src_v && wr_bank) begin
            buf1_even[wr_pair] <= src_d[data_w-1:0];
            buf1_odd[wr_pair]  <= src_d[word_w-1:data_w];
        end
    end

    // registered read, holds while exec is low
    always_ff @(posedge clk) begin
        if (exec) begin
            unique case ({rd_bank, rd_odd})
                2'b00: exec_src_data <= buf0_even[rd_pair];
                2'b01: exec_src_data <= buf0_odd[rd_pair];
                2'b10: exec_src_data <= buf1_even[rd_pair];
                2'b11: exec_src_data <= buf1_odd[rd_pair];
            endcase
        end
    end

endmodule

`default_nettype wire
